//--- hw/rv_mem_pkg.sv
`default_nettype none

package rv_mem_pkg;

    // data path width, one RV32 word
    localparam int XLEN = 32;

    // major opcodes for the two memory instruction groups
    localparam logic [6:0] LOAD_OP  = 7'b0000011;
    localparam logic [6:0] STORE_OP = 7'b0100011;

    // access size as decoded from funct3[1:0]
    // improper covers funct3 11 and every non-memory opcode
    typedef enum logic [1:0] {
        SIZE_WORD     = 2'b00,
        SIZE_HALF     = 2'b01,
        SIZE_BYTE     = 2'b10,
        SIZE_IMPROPER = 2'b11
    } access_size_t;

    // one enable bit per byte lane of a word
    typedef logic [3:0] lane_t;

    // operation handed over by the pipeline
    typedef struct packed {
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        // squashed instruction, a store must not reach memory
        logic            flush;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_op_t;

    // response returned with ack
    typedef struct packed {
        // extended load data, zero otherwise
        logic [XLEN-1:0] rdata;
        // op was a load or a store
        logic            accessed;
        // improper size or misaligned half/word
        logic            fault;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- hw/mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl (
    input  logic [6:0]               opcode,
    input  logic [2:0]               funct3,
    input  logic                     flush,
    output rv_mem_pkg::access_size_t access_size,
    output logic                     write_to_data_mem,
    output logic                     require_mem_access
);

    logic is_load;
    logic is_store;

    // major opcode compare since funct3 only means something for these two
    assign is_load  = (opcode == rv_mem_pkg::LOAD_OP);
    assign is_store = (opcode == rv_mem_pkg::STORE_OP);

    always_comb
    begin
        if (is_load || is_store)
        begin
            // size sits in the low bits while funct3[2] is the load unsigned flag
            case (funct3[1:0])
                2'b00:   access_size = rv_mem_pkg::SIZE_BYTE;
                2'b01:   access_size = rv_mem_pkg::SIZE_HALF;
                2'b10:   access_size = rv_mem_pkg::SIZE_WORD;
                default: access_size = rv_mem_pkg::SIZE_IMPROPER;
            endcase
        end
        else
        begin
            // not a memory instruction
            access_size = rv_mem_pkg::SIZE_IMPROPER;
        end
    end

    // a flushed store is dropped and loads never write
    assign write_to_data_mem = is_store && !flush;

    // any load or store needs the memory
    assign require_mem_access = is_load || is_store;

endmodule

`default_nettype wire

//--- hw/store_align.sv
`timescale 1ns/10ps
`default_nettype none

module store_align (
    input  rv_mem_pkg::access_size_t    access_size,
    input  logic [1:0]                  addr_lo,
    input  logic [rv_mem_pkg::XLEN-1:0] wdata,
    output rv_mem_pkg::lane_t           be,
    output logic [rv_mem_pkg::XLEN-1:0] wlane,
    output logic                        misaligned
);

    always_comb
    begin
        case (access_size)
            rv_mem_pkg::SIZE_BYTE:
            begin
                // one lane picked by both address bits
                be         = rv_mem_pkg::lane_t'(4'b0001 << addr_lo);
                // copy the byte into every lane, be selects the real one
                wlane      = {4{wdata[7:0]}};
                misaligned = 1'b0;
            end
            rv_mem_pkg::SIZE_HALF:
            begin
                // lower or upper half of the word
                be         = addr_lo[1] ? 4'b1100 : 4'b0011;
                wlane      = {2{wdata[15:0]}};
                // odd byte address cannot hold a half
                misaligned = addr_lo[0];
            end
            rv_mem_pkg::SIZE_WORD:
            begin
                be         = 4'b1111;
                wlane      = wdata;
                // word needs a 4-byte boundary
                misaligned = (addr_lo != 2'b00);
            end
            default:
            begin
                // improper size never writes
                be         = 4'b0000;
                wlane      = wdata;
                misaligned = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/load_extend.sv
`timescale 1ns/10ps
`default_nettype none

module load_extend (
    input  logic [rv_mem_pkg::XLEN-1:0] rword,
    input  rv_mem_pkg::access_size_t    access_size,
    input  logic [1:0]                  addr_lo,
    input  logic                        is_unsigned,
    output logic [rv_mem_pkg::XLEN-1:0] rdata
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // byte lane from the full address offset
    always_comb
    begin
        case (addr_lo)
            2'd0:    sel_byte = rword[7:0];
            2'd1:    sel_byte = rword[15:8];
            2'd2:    sel_byte = rword[23:16];
            default: sel_byte = rword[31:24];
        endcase
    end

    // half lane from address bit 1, bit 0 is a fault upstream
    assign sel_half = addr_lo[1] ? rword[31:16] : rword[15:0];

    always_comb
    begin
        case (access_size)
            rv_mem_pkg::SIZE_BYTE:
            begin
                // LBU fills with zeros, LB with the sign bit
                rdata = {{24{sel_byte[7] & !is_unsigned}}, sel_byte};
            end
            rv_mem_pkg::SIZE_HALF:
            begin
                rdata = {{16{sel_half[15] & !is_unsigned}}, sel_half};
            end
            rv_mem_pkg::SIZE_WORD:
            begin
                // nothing to extend on RV32
                rdata = rword;
            end
            default:
            begin
                rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem #(
    parameter int ADDR_W = 8
) (
    input  logic                        clk,
    input  logic                        we,
    input  logic [ADDR_W-1:0]           addr,
    input  rv_mem_pkg::lane_t           be,
    input  logic [rv_mem_pkg::XLEN-1:0] wdata,
    output logic [rv_mem_pkg::XLEN-1:0] rdata
);

    // number of words and byte lanes per word
    localparam int DEPTH = 2 ** ADDR_W;
    localparam int LANES = $bits(rv_mem_pkg::lane_t);

    // word array, contents are undefined until written
    logic [rv_mem_pkg::XLEN-1:0] mem [DEPTH];

    // byte-masked write, only enabled lanes change
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            for (int i = 0; i < LANES; i++)
            begin
                if (be[i])
                begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read, data valid one edge after the address
    // a read of the word being written returns the old value
    always_ff @(posedge clk)
    begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage #(
    parameter int ADDR_W = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  rv_mem_pkg::mem_op_t  op,
    output logic                 ack,
    output rv_mem_pkg::mem_rsp_t rsp
);

    // handshake FSM, one operation in flight
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND,
        ST_RELEASE
    } state_t;

    state_t                      state;
    rv_mem_pkg::mem_op_t         op_q;
    rv_mem_pkg::access_size_t    size;
    logic                        write;
    logic                        access;
    rv_mem_pkg::lane_t           be;
    logic [rv_mem_pkg::XLEN-1:0] wlane;
    logic                        misaligned;
    logic                        we;
    logic [rv_mem_pkg::XLEN-1:0] rword;
    logic [rv_mem_pkg::XLEN-1:0] load_data;
    logic                        is_load;

    // decode of the latched operation
    mem_ctrl u_ctrl (
        .opcode             (op_q.opcode),
        .funct3             (op_q.funct3),
        .flush              (op_q.flush),
        .access_size        (size),
        .write_to_data_mem  (write),
        .require_mem_access (access)
    );

    store_align u_align (
        .access_size (size),
        .addr_lo     (op_q.addr[1:0]),
        .wdata       (op_q.wdata),
        .be          (be),
        .wlane       (wlane),
        .misaligned  (misaligned)
    );

    // write only in the access cycle and never for a faulting op
    assign we = (state == ST_ACCESS) && write && !misaligned;

    data_mem #(
        .ADDR_W (ADDR_W)
    ) u_mem (
        .clk   (clk),
        .we    (we),
        .addr  (op_q.addr[ADDR_W+1:2]),
        .be    (be),
        .wdata (wlane),
        .rdata (rword)
    );

    // funct3[2] marks LBU/LHU
    load_extend u_ext (
        .rword       (rword),
        .access_size (size),
        .addr_lo     (op_q.addr[1:0]),
        .is_unsigned (op_q.funct3[2]),
        .rdata       (load_data)
    );

    assign is_load = (op_q.opcode == rv_mem_pkg::LOAD_OP);

    // op is captured on the edge that sees req, so it stays put until the next req
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && req)
        begin
            op_q <= op;
        end
    end

    // response built when rword is valid, held through the release phase
    always_ff @(posedge clk)
    begin
        if (state == ST_RESPOND)
        begin
            rsp.rdata    <= (is_load && !misaligned) ? load_data : '0;
            rsp.accessed <= access;
            rsp.fault    <= access && misaligned;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
            ack   <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (req)
                    begin
                        state <= ST_ACCESS;
                    end
                end
                // ram write or read happens on this edge
                ST_ACCESS:
                begin
                    state <= ST_RESPOND;
                end
                ST_RESPOND:
                begin
                    ack   <= 1'b1;
                    state <= ST_RELEASE;
                end
                // hold ack until the requester lets go
                default:
                begin
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sim/mem_stage_properties.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_properties (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic                 req,
    input wire logic                 ack,
    input wire rv_mem_pkg::mem_rsp_t rsp
);

    // reset leaves the stage idle with ack low
    ack_reset: assert property (@(posedge clk) rst |=> !ack)
        else $error("ack not low after reset");

    // ack only rises for a pending req
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) (!req && !ack) |=> !ack)
        else $error("ack rose without req");

    // response frozen during the ack phase
    rsp_stable: assert property (@(posedge clk) disable iff (rst) ack |=> $stable(rsp))
        else $error("rsp changed while ack high");

    // release takes one edge
    ack_release: assert property (@(posedge clk) disable iff (rst) (ack && !req) |=> !ack)
        else $error("ack did not fall after req dropped");

endmodule

bind mem_stage mem_stage_properties u_props (
    .clk (clk),
    .rst (rst),
    .req (req),
    .ack (ack),
    .rsp (rsp)
);

`default_nettype wire

//--- sim/mem_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_tb;

    localparam int ADDR_W       = 8;
    localparam int DEPTH        = 2 ** ADDR_W;
    localparam int CLK_PERIOD   = 20;
    // directed ops per group word 32 byte/half 64 fault 40 flush 16 non-memory 8
    localparam int DIRECTED_OPS = 160;
    localparam int RANDOM_OPS   = 400;
    localparam int TOTAL_OPS    = DEPTH + DIRECTED_OPS + RANDOM_OPS;
    // a handshake takes well under 10 cycles plus slack for reset
    localparam int TIMEOUT_NS   = (TOTAL_OPS * 10 + 100) * CLK_PERIOD;

    logic                 clk;
    logic                 rst;
    logic                 req;
    rv_mem_pkg::mem_op_t  op;
    logic                 ack;
    rv_mem_pkg::mem_rsp_t rsp;

    // byte-wide reference memory covering the same span as the DUT
    logic [7:0]  model_mem [4*DEPTH];
    logic [31:0] lfsr_state;

    mem_stage #(
        .ADDR_W (ADDR_W)
    ) dut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .op  (op),
        .ack (ack),
        .rsp (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois step with feedback mask 0x80200003
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    // n random bits with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic rv_mem_pkg::mem_op_t make_op(input logic [6:0]  opcode,
                                                    input logic [2:0]  funct3,
                                                    input logic        flush,
                                                    input logic [31:0] addr,
                                                    input logic [31:0] wdata);
        rv_mem_pkg::mem_op_t o;
        o.opcode = opcode;
        o.funct3 = funct3;
        o.flush  = flush;
        o.addr   = addr;
        o.wdata  = wdata;
        return o;
    endfunction

    // expected response from the RV32 load/store rules while stores update the model
    task automatic model_step(input rv_mem_pkg::mem_op_t o, output rv_mem_pkg::mem_rsp_t exp);
        int          nbytes;
        int          base;
        logic        bad;
        logic [31:0] val;
        exp = '0;
        if (o.opcode == rv_mem_pkg::LOAD_OP || o.opcode == rv_mem_pkg::STORE_OP)
        begin
            case (o.funct3[1:0])
                2'b00:   nbytes = 1;
                2'b01:   nbytes = 2;
                2'b10:   nbytes = 4;
                default: nbytes = 0;
            endcase
            base = int'(o.addr[ADDR_W+1:0]);
            // improper size or address not a multiple of the size
            if (nbytes == 0)
                bad = 1'b1;
            else
                bad = (base % nbytes) != 0;
            exp.accessed = 1'b1;
            exp.fault    = bad;
            if (!bad && o.opcode == rv_mem_pkg::STORE_OP && !o.flush)
            begin
                for (int i = 0; i < nbytes; i++)
                    model_mem[base+i] = o.wdata[8*i +: 8];
            end
            if (!bad && o.opcode == rv_mem_pkg::LOAD_OP)
            begin
                val = '0;
                for (int i = 0; i < nbytes; i++)
                    val[8*i +: 8] = model_mem[base+i];
                // funct3[2] clear means sign extension
                if (nbytes == 1 && !o.funct3[2] && val[7])
                    val[31:8] = '1;
                if (nbytes == 2 && !o.funct3[2] && val[15])
                    val[31:16] = '1;
                exp.rdata = val;
            end
        end
    endtask

    task automatic check_rsp(input string                name,
                             input rv_mem_pkg::mem_rsp_t exp,
                             input rv_mem_pkg::mem_rsp_t act);
        if (act !== exp)
        begin
            $display("ERR %s: expected rdata=%h acc=%b flt=%b actual rdata=%h acc=%b flt=%b",
                     name, exp.rdata, exp.accessed, exp.fault, act.rdata, act.accessed, act.fault);
            $display("sim failed");
            $fatal(1, "response mismatch");
        end
    endtask

    // one full four-phase handshake where hold keeps req up after ack
    task automatic run_op(input string name, input rv_mem_pkg::mem_op_t o, input int hold);
        rv_mem_pkg::mem_rsp_t exp;
        model_step(o, exp);
        @(negedge clk);
        op  = o;
        req = 1'b1;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        check_rsp(name, exp, rsp);
        if (hold > 0)
        begin
            repeat (hold) @(negedge clk);
            // response must survive the back-pressure
            check_rsp(name, exp, rsp);
        end
        req = 1'b0;
        // op is don't-care once req is low
        op  = ~o;
        @(negedge clk);
        while (ack)
            @(negedge clk);
    endtask

    task automatic run_directed();
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] r;
        // every word written once so model and RAM agree
        for (int i = 0; i < DEPTH; i++)
            run_op("preload", make_op(rv_mem_pkg::STORE_OP, 3'b010, 1'b0, 32'(i) << 2,
                                      rand_bits(32)), 0);
        for (int i = 0; i < 16; i++)
        begin
            a = rand_bits(ADDR_W + 2) & ~32'd3;
            run_op("sw", make_op(rv_mem_pkg::STORE_OP, 3'b010, 1'b0, a, rand_bits(32)), 0);
            run_op("lw", make_op(rv_mem_pkg::LOAD_OP, 3'b010, 1'b0, a, '0), 0);
        end
        for (int i = 0; i < 8; i++)
        begin
            a = rand_bits(ADDR_W + 2);
            w = a & ~32'd3;
            run_op("sb", make_op(rv_mem_pkg::STORE_OP, 3'b000, 1'b0, a, rand_bits(32)), 0);
            run_op("sb_lw", make_op(rv_mem_pkg::LOAD_OP, 3'b010, 1'b0, w, '0), 0);
            run_op("lb", make_op(rv_mem_pkg::LOAD_OP, 3'b000, 1'b0, a, '0), 0);
            run_op("lbu", make_op(rv_mem_pkg::LOAD_OP, 3'b100, 1'b0, a, '0), 0);
            a = a & ~32'd1;
            run_op("sh", make_op(rv_mem_pkg::STORE_OP, 3'b001, 1'b0, a, rand_bits(32)), 0);
            run_op("sh_lw", make_op(rv_mem_pkg::LOAD_OP, 3'b010, 1'b0, w, '0), 0);
            run_op("lh", make_op(rv_mem_pkg::LOAD_OP, 3'b001, 1'b0, a, '0), 0);
            run_op("lhu", make_op(rv_mem_pkg::LOAD_OP, 3'b101, 1'b0, a, '0), 0);
        end
        for (int i = 0; i < 8; i++)
        begin
            a = rand_bits(ADDR_W + 2) & ~32'd3;
            r = rand_bits(2);
            if (r == 0)
                r = 32'd1;
            run_op("sw_misaligned", make_op(rv_mem_pkg::STORE_OP, 3'b010, 1'b0, a + r,
                                            rand_bits(32)), 0);
            r = rand_bits(1);
            run_op("lh_odd", make_op(rv_mem_pkg::LOAD_OP, 3'b001, 1'b0, a + 32'd1 + (r << 1),
                                     '0), 0);
            run_op("store_improper", make_op(rv_mem_pkg::STORE_OP, 3'b011, 1'b0, a,
                                             rand_bits(32)), 0);
            run_op("load_improper", make_op(rv_mem_pkg::LOAD_OP, 3'b111, 1'b0, a, '0), 0);
            run_op("fault_lw", make_op(rv_mem_pkg::LOAD_OP, 3'b010, 1'b0, a, '0), 0);
        end
        // flushed store must leave the word alone
        for (int i = 0; i < 8; i++)
        begin
            a = rand_bits(ADDR_W + 2) & ~32'd3;
            run_op("sw_flush", make_op(rv_mem_pkg::STORE_OP, 3'b010, 1'b1, a, rand_bits(32)), 0);
            run_op("flush_lw", make_op(rv_mem_pkg::LOAD_OP, 3'b010, 1'b0, a, '0), 0);
        end
        for (int i = 0; i < 8; i++)
        begin
            r = rand_bits(7);
            // steer away from the two memory opcodes
            if (r[6:0] == rv_mem_pkg::LOAD_OP || r[6:0] == rv_mem_pkg::STORE_OP)
                r[6] = ~r[6];
            w = rand_bits(3);
            run_op("non_mem", make_op(r[6:0], w[2:0], 1'b0, rand_bits(32), rand_bits(32)), 0);
        end
    endtask

    task automatic run_random_mix();
        rv_mem_pkg::mem_op_t o;
        logic [31:0]         r;
        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            r = rand_bits(3);
            // 3/8 loads and 3/8 stores with the rest any opcode
            if (r < 3)
                o.opcode = rv_mem_pkg::LOAD_OP;
            else if (r < 6)
                o.opcode = rv_mem_pkg::STORE_OP;
            else
            begin
                r = rand_bits(7);
                o.opcode = r[6:0];
            end
            r = rand_bits(3);
            o.funct3 = r[2:0];
            r = rand_bits(2);
            o.flush = (r[1:0] == 2'b00);
            o.addr  = rand_bits(32);
            o.wdata = rand_bits(32);
            // mostly size-aligned with some faults left in
            r = rand_bits(2);
            if (r[1:0] != 2'b00)
            begin
                if (o.funct3[1:0] == 2'b10)
                    o.addr[1:0] = 2'b00;
                else if (o.funct3[1:0] == 2'b01)
                    o.addr[0] = 1'b0;
            end
            r = rand_bits(2);
            run_op($sformatf("mix %0d", i), o, int'(r[1:0]));
        end
    endtask

    // watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("handshake timed out after %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        req        = 1'b0;
        op         = '0;
        lfsr_state = 32'd34;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        run_directed();
        run_random_mix();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_mem_stage.f
hw/rv_mem_pkg.sv
hw/mem_ctrl.sv
hw/store_align.sv
hw/load_extend.sv
hw/data_mem.sv
hw/mem_stage.sv
sim/mem_stage_properties.sv
sim/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mem_stage_tb
FILELIST  ?= rv_mem_stage.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "sim passed"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
